// ==== rtl/cache_cfg.svh ====
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// word and address width in bits.
`define CACHE_XLEN 32
`define CACHE_SETS 8
`define CACHE_WORDS 4
`define CACHE_PORTS 2
`define CACHE_WB_DEPTH 2

// address layout, low to high: byte bits, word index, set index, tag.
`define CACHE_WORD_LSB 2
`define CACHE_WORD_BITS ($clog2(`CACHE_WORDS))
`define CACHE_SET_LSB (`CACHE_WORD_LSB + `CACHE_WORD_BITS)
`define CACHE_SET_BITS ($clog2(`CACHE_SETS))
`define CACHE_TAG_LSB (`CACHE_SET_LSB + `CACHE_SET_BITS)
`define CACHE_TAG_BITS (`CACHE_XLEN - `CACHE_TAG_LSB)

`endif

// ==== rtl/cache_pkg.sv ====
`include "cache_cfg.svh"

package cache_pkg;

  typedef enum logic [1:0] {
    INVALID,
    VALID,
    MODIFIED  // line differs from memory.
  } cache_state_e;

  typedef enum logic [1:0] {
    CTRL_IDLE,
    CTRL_EVICT,
    CTRL_WAIT_DRAIN,
    CTRL_REFILL
  } ctrl_state_e;

  typedef logic [`CACHE_WORDS-1:0][`CACHE_XLEN-1:0] line_t;

  typedef struct packed {
    logic                   read;
    logic                   write;
    logic [`CACHE_XLEN-1:0] address;
    logic [`CACHE_XLEN-1:0] wdata;
  } cache_req_t;

  typedef struct packed {
    logic                   hit;
    logic [`CACHE_XLEN-1:0] rdata;
  } cache_rsp_t;

  typedef struct packed {
    logic [`CACHE_XLEN-1:0] address;  // always line aligned.
    line_t                  line;
  } victim_t;

  typedef struct packed {
    logic                   read;
    logic                   write;
    logic [`CACHE_XLEN-1:0] address;
    line_t                  line;
  } mem_req_t;

  typedef struct packed {
    logic  ready;
    logic  done;
    line_t line;
  } mem_rsp_t;

  typedef struct packed {
    logic                   en;
    logic [`CACHE_XLEN-1:0] address;
    logic [`CACHE_XLEN-1:0] data;
  } word_write_t;

  typedef struct packed {
    logic                   en;
    logic [`CACHE_XLEN-1:0] address;
    line_t                  line;
  } line_fill_t;

endpackage

// ==== rtl/cache_store.sv ====
`timescale 1ns/100ps
`include "cache_cfg.svh"

module cache_store import cache_pkg::*; (
  input  logic                                       gsi,
  input  logic                                       reset,
  input  logic [`CACHE_PORTS-1:0][`CACHE_XLEN-1:0]   lookup_addr,
  output logic [`CACHE_PORTS-1:0]                    lookup_hit,
  output logic [`CACHE_PORTS-1:0][`CACHE_XLEN-1:0]   lookup_word,
  output cache_state_e [`CACHE_PORTS-1:0]            lookup_state,
  input  word_write_t [`CACHE_PORTS-1:0]             word_wr,
  input  line_fill_t                                 fill,
  input  logic [`CACHE_SET_BITS-1:0]                 victim_set,
  output victim_t                                    victim,
  output logic                                       victim_dirty
);

  logic [`CACHE_TAG_BITS-1:0] tag_q [`CACHE_SETS];
  cache_state_e               state_q [`CACHE_SETS];
  line_t                      line_q [`CACHE_SETS];

  logic [`CACHE_PORTS-1:0][`CACHE_SET_BITS-1:0]  look_set;
  logic [`CACHE_PORTS-1:0][`CACHE_WORD_BITS-1:0] look_word;
  logic [`CACHE_PORTS-1:0][`CACHE_TAG_BITS-1:0]  look_tag;
  logic [`CACHE_PORTS-1:0][`CACHE_SET_BITS-1:0]  wr_set;
  logic [`CACHE_PORTS-1:0][`CACHE_WORD_BITS-1:0] wr_word;
  logic [`CACHE_SET_BITS-1:0]                    fill_set;

  // both ports compare their tags in parallel.
  always_comb begin
    for (int p = 0; p < `CACHE_PORTS; p++) begin
      look_set[p]     = lookup_addr[p][`CACHE_SET_LSB +: `CACHE_SET_BITS];
      look_word[p]    = lookup_addr[p][`CACHE_WORD_LSB +: `CACHE_WORD_BITS];
      look_tag[p]     = lookup_addr[p][`CACHE_TAG_LSB +: `CACHE_TAG_BITS];
      lookup_state[p] = state_q[look_set[p]];
      lookup_word[p]  = line_q[look_set[p]][look_word[p]];
      lookup_hit[p]   = (state_q[look_set[p]] != INVALID) &&
                        (tag_q[look_set[p]] == look_tag[p]);
    end
  end

  always_comb begin
    fill_set = fill.address[`CACHE_SET_LSB +: `CACHE_SET_BITS];
    for (int p = 0; p < `CACHE_PORTS; p++) begin
      wr_set[p]  = word_wr[p].address[`CACHE_SET_LSB +: `CACHE_SET_BITS];
      wr_word[p] = word_wr[p].address[`CACHE_WORD_LSB +: `CACHE_WORD_BITS];
    end
  end

  always_ff @(posedge gsi) begin
    if (reset) begin
      for (int s = 0; s < `CACHE_SETS; s++) begin
        state_q[s] <= INVALID;
      end
    end else begin
      if (fill.en) begin
        state_q[fill_set] <= VALID;
      end
      for (int p = 0; p < `CACHE_PORTS; p++) begin
        if (word_wr[p].en) begin
          state_q[wr_set[p]] <= MODIFIED;
        end
      end
    end
  end

  always_ff @(posedge gsi) begin
    if (fill.en) begin
      tag_q[fill_set]  <= fill.address[`CACHE_TAG_LSB +: `CACHE_TAG_BITS];
      line_q[fill_set] <= fill.line;
    end
    for (int p = 0; p < `CACHE_PORTS; p++) begin
      if (word_wr[p].en) begin
        line_q[wr_set[p]][wr_word[p]] <= word_wr[p].data;
      end
    end
  end

  // the victim address is rebuilt from the stored tag.
  assign victim.address = {tag_q[victim_set], victim_set, {(`CACHE_SET_LSB){1'b0}}};
  assign victim.line    = line_q[victim_set];
  assign victim_dirty   = (state_q[victim_set] == MODIFIED);

  // the controller must keep a refill and a store off the same line.
  for (genvar p = 0; p < `CACHE_PORTS; p++) begin : g_fill_check
    a_fill_vs_write : assert property (@(posedge gsi) disable iff (reset)
      !(fill.en && word_wr[p].en && (wr_set[p] == fill_set)));
  end

endmodule

// ==== rtl/evict_buffer.sv ====
`timescale 1ns/100ps
`include "cache_cfg.svh"

module evict_buffer import cache_pkg::*; (
  input  logic    gsi,
  input  logic    reset,
  input  logic    push,
  input  victim_t entry,
  input  logic    pop,
  output victim_t head,
  output logic    empty,
  output logic    full
);

  localparam int ptr_bits = (`CACHE_WB_DEPTH > 1) ? $clog2(`CACHE_WB_DEPTH) : 1;
  localparam int cnt_bits = $clog2(`CACHE_WB_DEPTH + 1);

  victim_t              slots [`CACHE_WB_DEPTH];
  logic [ptr_bits-1:0]  wr_ptr;
  logic [ptr_bits-1:0]  rd_ptr;
  logic [cnt_bits-1:0]  count;

  function automatic logic [ptr_bits-1:0] next_ptr(input logic [ptr_bits-1:0] ptr);
    if (ptr == ptr_bits'(`CACHE_WB_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  always_ff @(posedge gsi) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // both or neither leave the fill level alone.
      endcase
    end
  end

  always_ff @(posedge gsi) begin
    if (push) begin
      slots[wr_ptr] <= entry;
    end
  end

  assign head  = slots[rd_ptr];
  assign empty = (count == '0);
  assign full  = (count == cnt_bits'(`CACHE_WB_DEPTH));

  a_no_pop_empty : assert property (@(posedge gsi) disable iff (reset) pop |-> !empty);
  a_no_push_full : assert property (@(posedge gsi) disable iff (reset) push |-> !full);

endmodule

// ==== rtl/cache_ctrl.sv ====
`timescale 1ns/100ps
`include "cache_cfg.svh"

module cache_ctrl import cache_pkg::*; (
  input  logic                                       gsi,
  input  logic                                       reset,
  input  cache_req_t [`CACHE_PORTS-1:0]              req,
  output cache_rsp_t [`CACHE_PORTS-1:0]              rsp,
  input  logic [`CACHE_PORTS-1:0]                    lookup_hit,
  input  logic [`CACHE_PORTS-1:0][`CACHE_XLEN-1:0]   lookup_word,
  input  cache_state_e [`CACHE_PORTS-1:0]            lookup_state,
  output word_write_t [`CACHE_PORTS-1:0]             word_wr,
  output line_fill_t                                 fill,
  output logic [`CACHE_SET_BITS-1:0]                 victim_set,
  input  victim_t                                    victim,
  input  logic                                       victim_dirty,
  output logic                                       wb_push,
  output victim_t                                    wb_entry,
  input  victim_t                                    wb_head,
  input  logic                                       wb_empty,
  input  logic                                       wb_full,
  output logic                                       wb_pop,
  output mem_req_t                                   mem_req,
  input  mem_rsp_t                                   mem_rsp
);

  ctrl_state_e                               state_q;
  ctrl_state_e                               state_d;
  logic [`CACHE_XLEN-1:0]                    miss_addr_q;
  logic [`CACHE_XLEN-1:0]                    miss_addr_d;
  logic                                      miss_found;
  logic                                      miss_needs_evict;
  logic [`CACHE_PORTS-1:0]                   active;
  logic [`CACHE_PORTS-1:0]                   grant;
  logic [`CACHE_PORTS-1:0]                   hit_q;
  logic [`CACHE_PORTS-1:0][`CACHE_XLEN-1:0]  rdata_q;
  logic                                      refill_done;

  // a port in its hit cycle still shows the old request.
  always_comb begin
    for (int p = 0; p < `CACHE_PORTS; p++) begin
      active[p] = (req[p].read || req[p].write) && !hit_q[p];
      grant[p]  = active[p] && lookup_hit[p];
      if (state_q != CTRL_IDLE &&
          req[p].address[`CACHE_SET_LSB +: `CACHE_SET_BITS] == victim_set) begin
        grant[p] = 1'b0;  // the line under replacement is off limits.
      end
      for (int q = 0; q < p; q++) begin
        if (grant[q] && req[q].write && req[p].write &&
            req[q].address[`CACHE_SET_LSB +: `CACHE_SET_BITS] ==
            req[p].address[`CACHE_SET_LSB +: `CACHE_SET_BITS]) begin
          grant[p] = 1'b0;
        end
      end
    end
  end

  // lower port numbers win, so the loop runs downwards.
  always_comb begin
    miss_found       = 1'b0;
    miss_addr_d      = miss_addr_q;
    miss_needs_evict = 1'b0;
    for (int p = `CACHE_PORTS - 1; p >= 0; p--) begin
      if (active[p] && !lookup_hit[p]) begin
        miss_found       = 1'b1;
        miss_addr_d      = {req[p].address[`CACHE_XLEN-1:`CACHE_SET_LSB],
                            {(`CACHE_SET_LSB){1'b0}}};
        miss_needs_evict = (lookup_state[p] != INVALID);
      end
    end
  end

  assign refill_done = (state_q == CTRL_REFILL) && mem_rsp.ready;

  always_comb begin
    state_d = state_q;
    case (state_q)
      CTRL_IDLE: begin
        if (miss_found) begin
          state_d = miss_needs_evict ? CTRL_EVICT : CTRL_WAIT_DRAIN;
        end
      end
      CTRL_EVICT: begin
        if (!victim_dirty || !wb_full) begin
          state_d = CTRL_WAIT_DRAIN;
        end
      end
      CTRL_WAIT_DRAIN: begin
        if (wb_empty) begin
          state_d = CTRL_REFILL;
        end
      end
      CTRL_REFILL: begin
        if (refill_done) begin
          state_d = CTRL_IDLE;
        end
      end
      default: state_d = CTRL_IDLE;
    endcase
  end

  always_ff @(posedge gsi) begin
    if (reset) begin
      state_q <= CTRL_IDLE;
      hit_q   <= '0;
    end else begin
      state_q <= state_d;
      hit_q   <= grant;
    end
  end

  always_ff @(posedge gsi) begin
    if (state_q == CTRL_IDLE) begin
      miss_addr_q <= miss_addr_d;
    end
    for (int p = 0; p < `CACHE_PORTS; p++) begin
      if (grant[p] && req[p].read) begin
        rdata_q[p] <= lookup_word[p];
      end
    end
  end

  always_comb begin
    for (int p = 0; p < `CACHE_PORTS; p++) begin
      rsp[p].hit         = hit_q[p];
      rsp[p].rdata       = rdata_q[p];
      word_wr[p].en      = grant[p] && req[p].write;
      word_wr[p].address = req[p].address;
      word_wr[p].data    = req[p].wdata;
    end
  end

  assign fill.en      = refill_done;
  assign fill.address = miss_addr_q;
  assign fill.line    = mem_rsp.line;

  assign victim_set = miss_addr_q[`CACHE_SET_LSB +: `CACHE_SET_BITS];
  assign wb_push    = (state_q == CTRL_EVICT) && victim_dirty && !wb_full;
  assign wb_entry   = victim;

  // a refill only starts on an empty buffer, so the write-back never meets a read.
  assign mem_req.read    = (state_q == CTRL_REFILL);
  assign mem_req.write   = !wb_empty;
  assign mem_req.address = mem_req.read ? miss_addr_q : wb_head.address;
  assign mem_req.line    = wb_head.line;
  assign wb_pop          = mem_req.write && mem_rsp.done;

  a_mem_excl : assert property (@(posedge gsi) disable iff (reset)
    !(mem_req.read && mem_req.write));
  // refills wait for the drain, so a dirty victim always finds room.
  a_push_room : assert property (@(posedge gsi) disable iff (reset)
    ((state_q == CTRL_EVICT) && victim_dirty) |-> !wb_full);

endmodule

// ==== rtl/data_cache.sv ====
`timescale 1ns/100ps
`include "cache_cfg.svh"

module data_cache import cache_pkg::*; (
  input  logic                          gsi,
  input  logic                          reset,
  input  cache_req_t [`CACHE_PORTS-1:0] req,
  output cache_rsp_t [`CACHE_PORTS-1:0] rsp,
  output mem_req_t                      mem_req,
  input  mem_rsp_t                      mem_rsp
);

  logic [`CACHE_PORTS-1:0][`CACHE_XLEN-1:0]  lookup_addr;
  logic [`CACHE_PORTS-1:0]                   lookup_hit;
  logic [`CACHE_PORTS-1:0][`CACHE_XLEN-1:0]  lookup_word;
  cache_state_e [`CACHE_PORTS-1:0]           lookup_state;
  word_write_t [`CACHE_PORTS-1:0]            word_wr;
  line_fill_t                                fill;
  logic [`CACHE_SET_BITS-1:0]                victim_set;
  victim_t                                   victim;
  logic                                      victim_dirty;
  logic                                      wb_push;
  victim_t                                   wb_entry;
  victim_t                                   wb_head;
  logic                                      wb_empty;
  logic                                      wb_full;
  logic                                      wb_pop;

  for (genvar p = 0; p < `CACHE_PORTS; p++) begin : g_addr
    assign lookup_addr[p] = req[p].address;
  end

  cache_ctrl i_ctrl (
    .gsi          (gsi),
    .reset        (reset),
    .req          (req),
    .rsp          (rsp),
    .lookup_hit   (lookup_hit),
    .lookup_word  (lookup_word),
    .lookup_state (lookup_state),
    .word_wr      (word_wr),
    .fill         (fill),
    .victim_set   (victim_set),
    .victim       (victim),
    .victim_dirty (victim_dirty),
    .wb_push      (wb_push),
    .wb_entry     (wb_entry),
    .wb_head      (wb_head),
    .wb_empty     (wb_empty),
    .wb_full      (wb_full),
    .wb_pop       (wb_pop),
    .mem_req      (mem_req),
    .mem_rsp      (mem_rsp)
  );

  cache_store i_store (
    .gsi          (gsi),
    .reset        (reset),
    .lookup_addr  (lookup_addr),
    .lookup_hit   (lookup_hit),
    .lookup_word  (lookup_word),
    .lookup_state (lookup_state),
    .word_wr      (word_wr),
    .fill         (fill),
    .victim_set   (victim_set),
    .victim       (victim),
    .victim_dirty (victim_dirty)
  );

  evict_buffer i_evict (
    .gsi   (gsi),
    .reset (reset),
    .push  (wb_push),
    .entry (wb_entry),
    .pop   (wb_pop),
    .head  (wb_head),
    .empty (wb_empty),
    .full  (wb_full)
  );

endmodule

// ==== dv/mem_model.sv ====
`timescale 1ns/100ps
`include "cache_cfg.svh"

module mem_model import cache_pkg::*; (
  input  logic     gsi,
  input  logic     reset,
  input  mem_req_t req,
  output mem_rsp_t rsp
);

  localparam int read_latency  = 3;
  localparam int write_latency = 2;

  logic [`CACHE_XLEN-1:0] words [logic [`CACHE_XLEN-3:0]];  // only written words are stored.
  int unsigned            rd_count;
  int unsigned            wr_count;

  function automatic logic [31:0] initial_word(input logic [31:0] addr);
    return {addr[15:0], addr[31:16]} ^ (addr * 32'h0001_0193) ^ 32'h4d3c_2b1a;
  endfunction

  function automatic logic [31:0] read_word(input logic [31:0] addr);
    if (words.exists(addr[31:2])) begin
      return words[addr[31:2]];
    end
    return initial_word(addr);
  endfunction

  always @(posedge gsi) begin
    rsp.ready <= 1'b0;
    rsp.done  <= 1'b0;
    if (reset) begin
      rd_count <= 0;
      wr_count <= 0;
    end else begin
      if (req.read && !rsp.ready) begin
        if (rd_count == read_latency - 1) begin
          rd_count  <= 0;
          rsp.ready <= 1'b1;
          for (int w = 0; w < `CACHE_WORDS; w++) begin
            rsp.line[w] <= read_word(req.address + 32'(4 * w));
          end
        end else begin
          rd_count <= rd_count + 1;
        end
      end else begin
        rd_count <= 0;
      end
      if (req.write && !rsp.done) begin
        if (wr_count == write_latency - 1) begin
          wr_count <= 0;
          rsp.done <= 1'b1;  // the line lands in the array with the done pulse.
          for (int w = 0; w < `CACHE_WORDS; w++) begin
            words[req.address[31:2] + 30'(w)] = req.line[w];
          end
        end else begin
          wr_count <= wr_count + 1;
        end
      end else begin
        wr_count <= 0;
      end
    end
  end

endmodule

// ==== dv/data_cache_tb.sv ====
`timescale 1ns/100ps
`include "cache_cfg.svh"

module data_cache_tb import cache_pkg::*; ();

  localparam int timeout_cycles = 200;
  localparam int random_ops     = 400;
  localparam int line_bits      = `CACHE_WORDS * `CACHE_XLEN;

  logic                          gsi = 1'b0;
  logic                          reset = 1'b1;
  logic                          reset_seen = 1'b0;
  cache_req_t [`CACHE_PORTS-1:0] req;
  cache_rsp_t [`CACHE_PORTS-1:0] rsp;
  cache_req_t                    port_req [`CACHE_PORTS];
  logic [`CACHE_PORTS-1:0]       port_busy;
  logic [`CACHE_PORTS-1:0]       hits;
  logic [`CACHE_PORTS-1:0]       fast_check;
  logic [`CACHE_XLEN-1:0]        exp_data [`CACHE_PORTS];
  logic [`CACHE_XLEN-1:0]        shadow [logic [`CACHE_XLEN-3:0]];
  mem_req_t                      mem_req;
  mem_rsp_t                      mem_rsp;
  int                            seed;
  int                            errors;
  int                            errors_at_start;
  int                            tests_passed;
  int                            tests_failed;
  string                         test_name;

  data_cache i_dut (
    .gsi     (gsi),
    .reset   (reset),
    .req     (req),
    .rsp     (rsp),
    .mem_req (mem_req),
    .mem_rsp (mem_rsp)
  );

  mem_model i_mem (
    .gsi   (gsi),
    .reset (reset),
    .req   (mem_req),
    .rsp   (mem_rsp)
  );

  always #2 gsi = ~gsi;

  always @(posedge gsi) begin
    reset_seen <= reset;  // high in every cycle that follows a reset edge.
  end

  function automatic logic [31:0] initial_word(input logic [31:0] addr);
    return {addr[15:0], addr[31:16]} ^ (addr * 32'h0001_0193) ^ 32'h4d3c_2b1a;
  endfunction

  function automatic logic [31:0] expected_word(input logic [31:0] addr);
    if (shadow.exists(addr[31:2])) begin
      return shadow[addr[31:2]];
    end
    return initial_word({addr[31:2], 2'b00});
  endfunction

  function automatic line_t expected_line(input logic [31:0] addr);
    line_t line;
    for (int w = 0; w < `CACHE_WORDS; w++) begin
      line[w] = expected_word(addr + 32'(4 * w));
    end
    return line;
  endfunction

  task automatic report_mismatch(input string what, input logic [line_bits-1:0] expected,
                                 input logic [line_bits-1:0] actual);
    $display("FAILED %s, %s: expected %0h, actual %0h", test_name, what, expected, actual);
    errors++;
  endtask

  task automatic report_problem(input string what);
    $display("%s: %s", test_name, what);
    errors++;
  endtask

  for (genvar p = 0; p < `CACHE_PORTS; p++) begin : g_port
    assign req[p]       = port_req[p];
    assign port_busy[p] = port_req[p].read || port_req[p].write;
    assign hits[p]      = rsp[p].hit;

    a_read_data : assert property (@(negedge gsi) disable iff (reset)
      (rsp[p].hit && port_req[p].read) |-> (rsp[p].rdata == exp_data[p]))
      else report_mismatch($sformatf("port %0d read", p), line_bits'(exp_data[p]),
                           line_bits'(rsp[p].rdata));

    a_hit_latency : assert property (@(negedge gsi) disable iff (reset)
      (fast_check[p] && $rose(port_busy[p])) |=> rsp[p].hit)
      else report_problem($sformatf("port %0d hit came later than one cycle", p));
  end

  a_reset_quiet : assert property (@(negedge gsi)
    reset_seen |-> ((hits == '0) && !mem_req.read && !mem_req.write))
    else report_problem("a hit or a memory strobe was high during reset");

  // a written-back line must carry the newest data of every word.
  a_writeback_data : assert property (@(negedge gsi) disable iff (reset)
    (mem_req.write && mem_rsp.done) |-> (mem_req.line == expected_line(mem_req.address)))
    else report_mismatch("write-back line", expected_line(mem_req.address), mem_req.line);

  task automatic begin_test(input string name);
    test_name       = name;
    errors_at_start = errors;
  endtask

  task automatic end_test();
    if (errors == errors_at_start) begin
      tests_passed++;
      $display("%s: passed", test_name);
    end else begin
      tests_failed++;
      $display("%s: %0d checks failed", test_name, errors - errors_at_start);
    end
  endtask

  task automatic access(input int p, input logic wr, input logic [31:0] addr,
                        input logic [31:0] data);
    cache_req_t r;
    logic       seen;
    r.read    = !wr;
    r.write   = wr;
    r.address = addr;
    r.wdata   = data;
    seen      = 1'b0;
    @(posedge gsi);
    exp_data[p] = expected_word(addr);
    port_req[p] <= r;
    for (int t = 0; t < timeout_cycles && !seen; t++) begin
      @(negedge gsi);
      seen = rsp[p].hit;
    end
    if (!seen) begin
      report_problem($sformatf("port %0d timed out waiting for a hit on %h", p, addr));
    end else if (wr) begin
      shadow[addr[31:2]] = data;
    end
    @(posedge gsi);
    port_req[p] <= '0;
  endtask

  task automatic reset_state();
    begin_test("reset state");
    repeat (2) @(posedge gsi);
    reset <= 1'b0;
    repeat (2) @(posedge gsi);
    end_test();
  endtask

  task automatic read_miss();
    begin_test("read miss");
    fork
      access(0, 1'b0, 32'h0000_1040, 32'h0);
      access(1, 1'b0, 32'h0000_2084, 32'h0);
    join
    access(1, 1'b0, 32'h0000_508c, 32'h0);
    end_test();
  endtask

  task automatic write_read();
    begin_test("write then read");
    access(0, 1'b1, 32'h0000_3038, 32'h1234_5678);  // write miss, refill, then the store.
    access(0, 1'b0, 32'h0000_3038, 32'h0);
    access(1, 1'b0, 32'h0000_3038, 32'h0);
    access(1, 1'b1, 32'h0000_3038, 32'h8765_4321);
    access(0, 1'b0, 32'h0000_3038, 32'h0);
    end_test();
  endtask

  task automatic resident_hits();
    begin_test("resident hits");
    fast_check = '1;
    access(0, 1'b0, 32'h0000_3038, 32'h0);
    fork
      access(0, 1'b0, 32'h0000_303c, 32'h0);
      access(1, 1'b0, 32'h0000_1040, 32'h0);
    join
    fork
      access(0, 1'b0, 32'h0000_3038, 32'h0);
      access(1, 1'b1, 32'h0000_3034, 32'h5a5a_0001);
    join
    access(1, 1'b0, 32'h0000_3034, 32'h0);
    fast_check = '0;
    end_test();
  endtask

  task automatic eviction();
    logic [31:0] base;
    begin_test("eviction and write-back");
    base = 32'h0000_0454;  // set 5, word 1, first tag 8.
    for (int k = 0; k < 4; k++) begin
      access(k % 2, 1'b1, base + 32'(k) * 32'h80, 32'hbeef_0000 + 32'(k));
    end
    fork
      access(0, 1'b1, 32'h0000_0854, 32'hcafe_0000);
      access(1, 1'b1, 32'h0000_0864, 32'hcafe_0001);
    join
    access(0, 1'b0, base, 32'h0);
    access(1, 1'b0, base - 32'h4, 32'h0);  // untouched word of the same line.
    access(1, 1'b0, base + 32'h180, 32'h0);
    end_test();
  endtask

  task automatic random_traffic();
    logic [31:0] bits;
    logic [31:0] addr0;
    logic [31:0] addr1;
    logic [31:0] data0;
    logic [31:0] data1;
    logic        wr0;
    logic        wr1;
    begin_test("random traffic");
    for (int i = 0; i < random_ops; i++) begin
      bits  = $random(seed);
      addr0 = bits & 32'h0000_01fc;
      wr0   = bits[12];
      bits  = $random(seed);
      addr1 = bits & 32'h0000_01fc;
      wr1   = bits[12];
      if (addr1 == addr0) begin
        addr1 = addr0 ^ 32'h4;  // the two ports never share a word.
      end
      data0 = $random(seed);
      data1 = $random(seed);
      fork
        access(0, wr0, addr0, data0);
        access(1, wr1, addr1, data1);
      join
    end
    end_test();
  endtask

  initial begin
    seed         = 32'h4082_e9ca;
    errors       = 0;
    tests_passed = 0;
    tests_failed = 0;
    fast_check   = '0;
    test_name    = "startup";
    for (int p = 0; p < `CACHE_PORTS; p++) begin
      port_req[p] = '0;
      exp_data[p] = '0;
    end
    reset_state();
    read_miss();
    write_read();
    resident_hits();
    eviction();
    random_traffic();
    $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
    if (tests_failed == 0 && errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// ==== data_cache.f ====
+incdir+rtl
rtl/cache_pkg.sv
rtl/cache_store.sv
rtl/evict_buffer.sv
rtl/cache_ctrl.sv
rtl/data_cache.sv
dv/mem_model.sv
dv/data_cache_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= data_cache_tb
FILELIST  ?= data_cache.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard rtl/*.svh)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q '^Test OK$$' $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
